/* include/rast_ref_model.svh */
// Rasterizer reference model
`ifndef RAST_REF_MODEL_SVH
`define RAST_REF_MODEL_SVH

typedef struct packed {
    hit_t hit;
    rgb_t color;
} expect_t;

expect_t exp_q[$]; // Hits still to come, oldest first

// Sample spacing in fixed point
function automatic longint spacing(input subsample_t sub);
    longint unit;
    unit = longint'(1) << RADIX;
    case (sub)
        4'b0100: return unit / 2;
        4'b0010: return unit / 4;
        4'b0001: return unit / 8;
        default: return unit;
    endcase
endfunction

// Cross product of (b - a) with (s - a)
function automatic longint edge_value(input longint ax, ay, bx, by, sx, sy);
    return (bx - ax) * (sy - ay) - (by - ay) * (sx - ax);
endfunction

// Appends the inside samples of one triangle in row-major order
function automatic void add_expected(input triangle_t t, input rgb_t c,
                                     input sample_t scr, input subsample_t sub);
    longint  step;
    longint  vx[3];
    longint  vy[3];
    longint  x_lo, x_hi, y_lo, y_hi;
    longint  x, y;
    expect_t e;
    step  = spacing(sub);
    vx[0] = t.v0.x;
    vy[0] = t.v0.y;
    vx[1] = t.v1.x;
    vy[1] = t.v1.y;
    vx[2] = t.v2.x;
    vy[2] = t.v2.y;
    x_lo = vx[0];
    x_hi = vx[0];
    y_lo = vy[0];
    y_hi = vy[0];
    for (int i = 1; i < 3; i++) begin
        if (vx[i] < x_lo) x_lo = vx[i];
        if (vx[i] > x_hi) x_hi = vx[i];
        if (vy[i] < y_lo) y_lo = vy[i];
        if (vy[i] > y_hi) y_hi = vy[i];
    end
    if (x_lo < 0) x_lo = 0;
    if (y_lo < 0) y_lo = 0;
    if (x_hi > scr.x) x_hi = scr.x;
    if (y_hi > scr.y) y_hi = scr.y;
    if (x_hi < 0 || y_hi < 0) return; // Wholly left of or below the screen
    x_lo = x_lo - x_lo % step;
    y_lo = y_lo - y_lo % step;
    x_hi = x_hi - x_hi % step;
    y_hi = y_hi - y_hi % step;
    for (y = y_lo; y <= y_hi; y += step) begin
        for (x = x_lo; x <= x_hi; x += step) begin
            if (edge_value(vx[0], vy[0], vx[1], vy[1], x, y) > 0 &&
                edge_value(vx[1], vy[1], vx[2], vy[2], x, y) > 0 &&
                edge_value(vx[2], vy[2], vx[0], vy[0], x, y) > 0) begin
                e.hit.x = coord_t'(x);
                e.hit.y = coord_t'(y);
                e.hit.z = t.v0.z; // Flat z
                e.color = c;
                exp_q.push_back(e);
            end
        end
    end
endfunction

`endif

/* bench/rast_tb.sv */
// Rasterizer testbench
`timescale 1ns/1ps

module rast_tb;
    import rast_pkg::*;

    localparam int WAIT_LIMIT = 20000; // Cycles allowed per wait
    localparam int QUIET      = 8;     // Idle cycles that outlast the pipeline depth

    logic       clk;
    logic       rst_n;
    triangle_t  triangle;
    rgb_t       color;
    logic       tri_valid;
    sample_t    screen;
    subsample_t subsample;
    logic       halt;
    hit_t       hit;
    rgb_t       hit_color;
    logic       hit_valid;

    int    errors;
    int    hits_checked;
    string test_name;

    `include "rast_ref_model.svh"

    rast UUT (.*);

    always #2 clk = ~clk;

    // Each hit against the head of the expected list
    always @(negedge clk) begin
        expect_t head;
        if (rst_n && hit_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("[%s] DUT produced a hit at x=%0d y=%0d that the model does not have",
                         test_name, hit.x, hit.y);
            end else begin
                head = exp_q.pop_front();
                hits_checked++;
                assert (hit == head.hit) else begin
                    errors++;
                    $display("** Error [%s] hit: expected %h, actual %h", test_name, head.hit, hit);
                end
                assert (hit_color == head.color) else begin
                    errors++;
                    $display("** Error [%s] hit_color: expected %h, actual %h",
                             test_name, head.color, hit_color);
                end
            end
        end
    end

    // Clipped hits stay on the screen
    assert property (@(negedge clk) disable iff (!rst_n)
        hit_valid |-> (hit.x >= 0 && hit.x <= screen.x && hit.y >= 0 && hit.y <= screen.y))
    else begin
        errors++;
        $display("** Error [%s] hit position: expected within 0..%0d, 0..%0d, actual %0d, %0d",
                 test_name, screen.x, screen.y, hit.x, hit.y);
    end

    task automatic end_run();
        $display("Hits checked: %0d, errors: %0d", hits_checked, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("[%s] Gave up after %0d cycles waiting for %s", test_name, WAIT_LIMIT, what);
        end_run();
    endtask

    function automatic coord_t px(input int whole, input int frac);
        return coord_t'(whole * (1 << RADIX) + frac);
    endfunction

    function automatic triangle_t make_tri(input coord_t ax, ay, bx, by, cx, cy, z);
        triangle_t t;
        t.v0 = '{x: ax, y: ay, z: z};
        t.v1 = '{x: bx, y: by, z: z + px(1, 0)};
        t.v2 = '{x: cx, y: cy, z: z + px(2, 0)};
        return t;
    endfunction

    // Small random triangle on screen, wound counter-clockwise
    function automatic triangle_t random_tri();
        triangle_t t;
        vertex_t   v;
        coord_t    bx;
        coord_t    by;
        longint    winding;
        bx = px($urandom_range(0, 48), $urandom_range(0, 1023));
        by = px($urandom_range(0, 34), $urandom_range(0, 1023));
        t  = make_tri(bx + px($urandom_range(0, 11), $urandom_range(0, 1023)),
                      by + px($urandom_range(0, 11), $urandom_range(0, 1023)),
                      bx + px($urandom_range(0, 11), $urandom_range(0, 1023)),
                      by + px($urandom_range(0, 11), $urandom_range(0, 1023)),
                      bx + px($urandom_range(0, 11), $urandom_range(0, 1023)),
                      by + px($urandom_range(0, 11), $urandom_range(0, 1023)),
                      coord_t'($urandom));
        winding = (longint'(t.v1.x) - t.v0.x) * (longint'(t.v2.y) - t.v0.y) -
                  (longint'(t.v1.y) - t.v0.y) * (longint'(t.v2.x) - t.v0.x);
        if (winding < 0) begin
            v    = t.v1;
            t.v1 = t.v2;
            t.v2 = v;
        end
        return t;
    endfunction

    function automatic rgb_t random_color();
        return '{r: color_t'($urandom), g: color_t'($urandom), b: color_t'($urandom)};
    endfunction

    // Holds the triangle until an edge with halt low takes it
    task automatic send_triangle(input triangle_t t, input rgb_t c);
        int waited;
        add_expected(t, c, screen, subsample);
        triangle  = t;
        color     = c;
        tri_valid = 1'b1;
        waited    = 0;
        while (halt) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) timed_out("halt to release the triangle");
        end
        @(negedge clk);
        tri_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        int quiet;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) timed_out("the remaining expected hits");
        end
        waited = 0;
        quiet  = 0;
        while (quiet < QUIET) begin // Catches late extra hits too
            @(negedge clk);
            quiet = halt ? 0 : quiet + 1;
            waited++;
            if (waited > WAIT_LIMIT) timed_out("halt to stay low");
        end
    endtask

    task automatic rasterize(input string name, input triangle_t t, input rgb_t c);
        test_name = name;
        send_triangle(t, c);
        wait_drained();
    endtask

    initial begin
        triangle_t ccw;
        triangle_t cw;
        rgb_t      paint;
        void'($urandom(32'h29ed));
        clk          = 1'b0;
        rst_n        = 1'b0;
        triangle     = '0;
        color        = '0;
        tri_valid    = 1'b0;
        screen.x     = px(63, 0);
        screen.y     = px(47, 0);
        subsample    = SUB_PIXEL;
        errors       = 0;
        hits_checked = 0;
        test_name    = "reset";
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!halt && !hit_valid) else begin
            errors++;
            $display("** Error [reset] halt, hit_valid: expected 0 0, actual %b %b",
                     halt, hit_valid);
        end

        paint = '{r: 24'h00ff10, g: 24'h123456, b: 24'habcdef};
        ccw   = make_tri(px(2, 100), px(2, 300), px(13, 700), px(4, 50),
                         px(6, 20), px(12, 900), px(-3, 0));
        cw    = make_tri(ccw.v0.x, ccw.v0.y, ccw.v2.x, ccw.v2.y,
                         ccw.v1.x, ccw.v1.y, ccw.v0.z);
        rasterize("one_pixel", ccw, paint);
        subsample = SUB_HALF;
        rasterize("half_pixel", ccw, paint);
        subsample = SUB_QUARTER;
        rasterize("quarter_pixel", ccw, paint);
        subsample = SUB_EIGHTH;
        rasterize("eighth_pixel", ccw, paint);

        subsample = SUB_PIXEL;
        rasterize("clockwise", cw, paint);
        rasterize("off_screen", make_tri(px(70, 0), px(5, 0), px(80, 0), px(6, 0),
                                         px(75, 0), px(15, 0), px(0, 0)), paint);
        rasterize("on_edge", make_tri(px(2, 0), px(2, 0), px(4, 0), px(2, 0),
                                      px(2, 0), px(4, 0), px(1, 0)), paint);
        rasterize("clipping", make_tri(px(-5, 0), px(-4, 0), px(70, 0), px(-3, 0),
                                       px(20, 0), px(55, 0), px(2, 0)), random_color());

        test_name = "back_to_back";
        repeat (12) send_triangle(random_tri(), random_color());
        wait_drained();

        end_run();
    end

endmodule

/* logic/rast.sv */
// Triangle rasterizer top level
`timescale 1ns/1ps

module rast (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rast_pkg::triangle_t  triangle,
    input  rast_pkg::rgb_t       color,
    input  logic                 tri_valid,
    input  rast_pkg::sample_t    screen,     // Screen maximum, quasi-static
    input  rast_pkg::subsample_t subsample,  // Quasi-static
    output logic                 halt,
    output rast_pkg::hit_t       hit,
    output rast_pkg::rgb_t       hit_color,
    output logic                 hit_valid
);
    import rast_pkg::*;

    box_pkt_t    box_pkt;
    logic        box_valid;
    sample_pkt_t sample_pkt;
    logic        sample_valid;

    rast_bbox u_bbox (
        .clk       (clk),
        .rst_n     (rst_n),
        .triangle  (triangle),
        .color     (color),
        .tri_valid (tri_valid),
        .screen    (screen),
        .subsample (subsample),
        .halt      (halt),
        .box_pkt   (box_pkt),
        .box_valid (box_valid)
    );

    // Iterator halt also stalls the source
    rast_iterator u_iterator (
        .clk          (clk),
        .rst_n        (rst_n),
        .box_pkt      (box_pkt),
        .box_valid    (box_valid),
        .subsample    (subsample),
        .halt         (halt),
        .sample_pkt   (sample_pkt),
        .sample_valid (sample_valid)
    );

    rast_sample_test u_sample_test (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_pkt   (sample_pkt),
        .sample_valid (sample_valid),
        .hit          (hit),
        .hit_color    (hit_color),
        .hit_valid    (hit_valid)
    );

endmodule

/* logic/rast_bbox.sv */
// Triangle bounding box
`timescale 1ns/1ps

module rast_bbox (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rast_pkg::triangle_t  triangle,
    input  rast_pkg::rgb_t       color,
    input  logic                 tri_valid,
    input  rast_pkg::sample_t    screen,    // Screen maximum
    input  rast_pkg::subsample_t subsample,
    input  logic                 halt,
    output rast_pkg::box_pkt_t   box_pkt,
    output logic                 box_valid
);
    import rast_pkg::*;

    // Stage one registers
    triangle_t tri_q;
    rgb_t      color_q;
    logic      valid_q;

    coord_t grid_mask;
    coord_t x_lo;
    coord_t x_hi;
    coord_t y_lo;
    coord_t y_hi;
    box_t   box;
    logic   box_nonempty;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Raise to the screen origin, then round down to the grid
    function automatic coord_t clip_low(input coord_t v, input coord_t mask);
        coord_t c;
        c = v[SIGFIG-1] ? coord_t'(0) : v;
        return c & mask;
    endfunction

    // Lower to the screen maximum, then round down to the grid
    function automatic coord_t clip_high(input coord_t v, input coord_t limit,
                                         input coord_t mask);
        coord_t c;
        c = (v > limit) ? limit : v;
        return c & mask;
    endfunction

    always_comb begin
        grid_mask = ~(grid_step(subsample) - coord_t'(1)); // Clears bits below the step
        x_lo = clip_low(min3(tri_q.v0.x, tri_q.v1.x, tri_q.v2.x), grid_mask);
        y_lo = clip_low(min3(tri_q.v0.y, tri_q.v1.y, tri_q.v2.y), grid_mask);
        x_hi = clip_high(max3(tri_q.v0.x, tri_q.v1.x, tri_q.v2.x), screen.x, grid_mask);
        y_hi = clip_high(max3(tri_q.v0.y, tri_q.v1.y, tri_q.v2.y), screen.y, grid_mask);

        box.x_min = x_lo;
        box.y_min = y_lo;
        box.x_max = x_hi;
        box.y_max = y_hi;

        // Off-screen triangles end up with an inverted box
        box_nonempty = (x_lo <= x_hi) && (y_lo <= y_hi);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            box_valid <= 1'b0;
        end else if (!halt) begin
            valid_q   <= tri_valid;
            box_valid <= valid_q && box_nonempty;
        end
    end

    // Both stages freeze while the iterator is busy
    always_ff @(posedge clk) begin
        if (!halt) begin
            tri_q            <= triangle;
            color_q          <= color;
            box_pkt.triangle <= tri_q;
            box_pkt.color    <= color_q;
            box_pkt.box      <= box;
        end
    end

endmodule

/* logic/rast_iterator.sv */
// Sample grid iterator
`timescale 1ns/1ps

module rast_iterator (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rast_pkg::box_pkt_t    box_pkt,
    input  logic                  box_valid,
    input  rast_pkg::subsample_t  subsample,
    output logic                  halt,
    output rast_pkg::sample_pkt_t sample_pkt,
    output logic                  sample_valid
);
    import rast_pkg::*;

    iter_state_t state;
    box_pkt_t    cur;     // Box being walked
    sample_t     pos;     // Sample on the output
    coord_t      step;
    coord_t      next_x;
    coord_t      next_y;
    logic        row_end;
    logic        last;    // Next sample closes the box
    logic        single;  // Incoming box has one sample

    always_comb begin
        step    = grid_step(subsample);
        row_end = (pos.x == cur.box.x_max);

        // Row-major walk, wrap to x_min at the end of a row
        next_x = row_end ? cur.box.x_min : coord_t'(pos.x + step);
        next_y = row_end ? coord_t'(pos.y + step) : pos.y;

        last   = (next_x == cur.box.x_max) && (next_y == cur.box.y_max);
        single = (box_pkt.box.x_min == box_pkt.box.x_max) &&
                 (box_pkt.box.y_min == box_pkt.box.y_max);
    end

    // Upstream stalls for the whole walk
    assign halt = (state == WALK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            sample_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    sample_valid <= box_valid; // First sample goes out at once
                    if (box_valid && !single) begin
                        state <= WALK;
                    end
                end
                WALK: begin
                    sample_valid <= 1'b1;
                    if (last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state        <= IDLE;
                    sample_valid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (box_valid) begin
                cur   <= box_pkt;
                pos.x <= box_pkt.box.x_min;
                pos.y <= box_pkt.box.y_min;
            end
        end else begin
            pos.x <= next_x;
            pos.y <= next_y;
        end
    end

    assign sample_pkt.triangle = cur.triangle;
    assign sample_pkt.color    = cur.color;
    assign sample_pkt.sample   = pos;

endmodule

/* logic/rast_pkg.sv */
// Rasterizer shared types
package rast_pkg;

    localparam int SIGFIG = 24; // Coordinate and color width
    localparam int RADIX  = 10; // Fraction bits

    typedef logic signed [SIGFIG-1:0] coord_t;
    typedef logic [SIGFIG-1:0]        color_t;
    typedef logic [3:0]               subsample_t; // One-hot sample spacing

    // Sample spacing codes
    localparam subsample_t SUB_PIXEL   = 4'b1000;
    localparam subsample_t SUB_HALF    = 4'b0100;
    localparam subsample_t SUB_QUARTER = 4'b0010;
    localparam subsample_t SUB_EIGHTH  = 4'b0001;

    localparam coord_t PIXEL = coord_t'(1 << RADIX); // One pixel in fixed point

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    typedef struct packed {
        coord_t x_min;
        coord_t y_min;
        coord_t x_max;
        coord_t y_max;
    } box_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } sample_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } hit_t;

    typedef struct packed {
        triangle_t triangle;
        rgb_t      color;
        box_t      box;
    } box_pkt_t;

    typedef struct packed {
        triangle_t triangle;
        rgb_t      color;
        sample_t   sample;
    } sample_pkt_t;

    typedef enum logic {
        IDLE,
        WALK
    } iter_state_t;

    // Grid step in fixed point for a spacing code
    function automatic coord_t grid_step(input subsample_t subsample);
        coord_t step;
        case (subsample)
            SUB_PIXEL:   step = PIXEL;
            SUB_HALF:    step = PIXEL >>> 1;
            SUB_QUARTER: step = PIXEL >>> 2;
            SUB_EIGHTH:  step = PIXEL >>> 3;
            default:     step = PIXEL; // Illegal code, fall back to whole pixels
        endcase
        return step;
    endfunction

endpackage

/* logic/rast_sample_test.sv */
// Edge function sample test
`timescale 1ns/1ps

module rast_sample_test (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rast_pkg::sample_pkt_t sample_pkt,
    input  logic                  sample_valid,
    output rast_pkg::hit_t        hit,
    output rast_pkg::rgb_t        hit_color,
    output logic                  hit_valid
);
    import rast_pkg::*;

    typedef logic signed [SIGFIG:0]     diff_t;     // One coordinate difference
    typedef logic signed [2*SIGFIG+2:0] edge_val_t; // Full cross product

    vertex_t v0;
    vertex_t v1;
    vertex_t v2;
    sample_t s;

    // Stage one registers
    edge_val_t e01_q;
    edge_val_t e12_q;
    edge_val_t e20_q;
    sample_t   sample_q;
    coord_t    z_q;
    rgb_t      color_q;
    logic      valid_q;

    logic is_inside;

    function automatic diff_t diff(input coord_t p, input coord_t q);
        return p - q;
    endfunction

    // (b - a) x (s - a), positive left of the edge
    function automatic edge_val_t edge_fn(input vertex_t a, input vertex_t b,
                                          input sample_t smp);
        return diff(b.x, a.x) * diff(smp.y, a.y) - diff(b.y, a.y) * diff(smp.x, a.x);
    endfunction

    assign v0 = sample_pkt.triangle.v0;
    assign v1 = sample_pkt.triangle.v1;
    assign v2 = sample_pkt.triangle.v2;
    assign s  = sample_pkt.sample;

    always_ff @(posedge clk) begin
        e01_q    <= edge_fn(v0, v1, s);
        e12_q    <= edge_fn(v1, v2, s);
        e20_q    <= edge_fn(v2, v0, s);
        sample_q <= s;
        z_q      <= v0.z; // No z interpolation
        color_q  <= sample_pkt.color;
    end

    // Strictly inside, so samples on an edge miss
    assign is_inside = (e01_q > 0) && (e12_q > 0) && (e20_q > 0);

    always_ff @(posedge clk) begin
        hit.x     <= sample_q.x;
        hit.y     <= sample_q.y;
        hit.z     <= z_q;
        hit_color <= color_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            valid_q   <= sample_valid;
            hit_valid <= valid_q && is_inside;
        end
    end

endmodule

/* rast.f */
+incdir+include
logic/rast_pkg.sv
logic/rast_bbox.sv
logic/rast_iterator.sv
logic/rast_sample_test.sv
logic/rast.sv
bench/rast_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rasterizer testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f rast.f --top-module rast_tb -o rast_sim \
    && ./obj_dir/rast_sim 2>&1 | tee sim.log \
    || { echo "Result: build or simulation did not complete"; exit 1; }

grep -q "Errors found" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "No errors" sim.log || { echo "Result: no verdict in log"; exit 1; }
echo "Result: PASS"
